//--- src/videoPkg.sv
// Video source types: coordinate, colour, pattern, config and pixel structs, register offsets.
`default_nettype none

package videoPkg;

    // Plain vectors for widths with a meaning.
    typedef logic [11:0] coordT;     // Pixel coordinate or frame size.
    typedef logic [23:0] rgbT;       // Red [23:16], green [15:8], blue [7:0].
    typedef logic [7:0]  regOffsetT; // Byte offset of a host register.
    typedef logic [1:0]  axiRespT;   // AXI response code.

    // Pattern selection, written through bits 2:1 of the control register.
    typedef enum logic [1:0]
    {
        patSolid    = 2'd0, // Solid colour register.
        patGradient = 2'd1, // Red from column, green from row.
        patChecker  = 2'd2, // 8x8 black and white squares.
        patBars     = 2'd3  // Eight vertical colour bars, 16 pixels wide.
    } patternT;

    // Host configuration as seen by the position generator and pattern stage.
    typedef struct packed
    {
        logic    enable;
        patternT pattern;
        coordT   hActive; // Active width, zero acts as one.
        coordT   vActive; // Active height, zero acts as one.
        rgbT     solid;
    } videoCfgT;

    // Next position to be produced, with its frame and line markers.
    typedef struct packed
    {
        coordT hPos;
        coordT vPos;
        logic  frameStart; // First pixel of the frame.
        logic  lineEnd;    // Last column of the line.
    } pixelPosT;

    // One pixel on the output stream.
    typedef struct packed
    {
        rgbT  rgb;
        logic sof;
        logic eol;
    } videoPixelT;

    // Register map.
    localparam regOffsetT regCtrl       = 8'h00; // Bit 0 enable, bits 2:1 pattern.
    localparam regOffsetT regHActive    = 8'h04;
    localparam regOffsetT regVActive    = 8'h08;
    localparam regOffsetT regSolid      = 8'h0C;
    localparam regOffsetT regFrameCount = 8'h10; // Read-only.

    localparam axiRespT respOkay = 2'b00;

endpackage

`default_nettype wire

//--- src/axiLiteRegs.sv
// AXI4-Lite slave with the configuration registers and the completed-frame counter.
`timescale 1ns/1ps
`default_nettype none

module axiLiteRegs
#(
    parameter int pAddrWidth = 5
)(
    input  wire logic                    iClk,
    input  wire logic                    rstN,
    // Write address and data.
    input  wire logic [pAddrWidth-1:0]   awAddr,
    input  wire logic                    awValid,
    output logic                         awReady,
    input  wire logic [31:0]             wData,
    input  wire logic [3:0]              wStrb,
    input  wire logic                    wValid,
    output logic                         wReady,
    // Write response.
    output videoPkg::axiRespT            bResp,
    output logic                         bValid,
    input  wire logic                    bReady,
    // Read address and data.
    input  wire logic [pAddrWidth-1:0]   arAddr,
    input  wire logic                    arValid,
    output logic                         arReady,
    output logic [31:0]                  rData,
    output videoPkg::axiRespT            rResp,
    output logic                         rValid,
    input  wire logic                    rReady,
    // Video side.
    input  wire logic                    frameDone,
    output videoPkg::videoCfgT           cfg
);

    logic                  awHeld;    // Write address captured.
    logic                  wHeld;     // Write data captured.
    logic [pAddrWidth-1:0] awAddrQ;
    logic [31:0]           wDataQ;
    logic [3:0]            wStrbQ;
    logic                  doWrite;   // Both halves present, response slot free.
    logic [31:0]           frameCount;

    // Word-aligned byte address.
    function automatic logic [pAddrWidth-1:0] wordAddr(input logic [pAddrWidth-1:0] addr);
        return {addr[pAddrWidth-1:2], 2'b00};
    endfunction

    // Byte-lane merge of new data into an old register value.
    function automatic logic [31:0] mergeStrb(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
        logic [31:0] merged;
        merged = old;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                merged[8*i +: 8] = data[8*i +: 8];
        end
        return merged;
    endfunction

    assign awReady = !awHeld && !bValid; // One write in flight.
    assign wReady  = !wHeld && !bValid;
    assign doWrite = awHeld && wHeld && !bValid;
    assign bResp   = videoPkg::respOkay;
    assign arReady = !rValid;            // One read in flight.
    assign rResp   = videoPkg::respOkay;

    // Write channel handshake state.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            awHeld <= 1'b0;
            wHeld  <= 1'b0;
            bValid <= 1'b0;
        end
        else
        begin
            if (awValid && awReady)
                awHeld <= 1'b1;
            else if (doWrite)
                awHeld <= 1'b0;
            if (wValid && wReady)
                wHeld <= 1'b1;
            else if (doWrite)
                wHeld <= 1'b0;
            if (doWrite)
                bValid <= 1'b1;        // Response with the register update.
            else if (bReady)
                bValid <= 1'b0;
        end
    end

    // Captured address and data.
    always_ff @(posedge iClk)
    begin
        if (awValid && awReady)
            awAddrQ <= awAddr;
        if (wValid && wReady)
        begin
            wDataQ <= wData;
            wStrbQ <= wStrb;
        end
    end

    // Configuration registers.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            cfg <= '0;
        end
        else if (doWrite)
        begin
            case (wordAddr(awAddrQ))
                pAddrWidth'(videoPkg::regCtrl):
                begin
                    if (wStrbQ[0])
                    begin
                        cfg.enable  <= wDataQ[0];
                        cfg.pattern <= videoPkg::patternT'(wDataQ[2:1]);
                    end
                end
                pAddrWidth'(videoPkg::regHActive):
                    cfg.hActive <= videoPkg::coordT'(mergeStrb(32'(cfg.hActive), wDataQ, wStrbQ));
                pAddrWidth'(videoPkg::regVActive):
                    cfg.vActive <= videoPkg::coordT'(mergeStrb(32'(cfg.vActive), wDataQ, wStrbQ));
                pAddrWidth'(videoPkg::regSolid):
                    cfg.solid <= videoPkg::rgbT'(mergeStrb(32'(cfg.solid), wDataQ, wStrbQ));
                default: ; // Frame count is read-only, the rest unmapped.
            endcase
        end
    end

    // Completed frames.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            frameCount <= '0;
        else if (frameDone)
            frameCount <= frameCount + 32'd1;
    end

    // Read channel handshake.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            rValid <= 1'b0;
        else if (arValid && arReady)
            rValid <= 1'b1;
        else if (rReady)
            rValid <= 1'b0;
    end

    // Read data mux, zero at unmapped offsets.
    always_ff @(posedge iClk)
    begin
        if (arValid && arReady)
        begin
            case (wordAddr(arAddr))
                pAddrWidth'(videoPkg::regCtrl):       rData <= {29'd0, cfg.pattern, cfg.enable};
                pAddrWidth'(videoPkg::regHActive):    rData <= 32'(cfg.hActive);
                pAddrWidth'(videoPkg::regVActive):    rData <= 32'(cfg.vActive);
                pAddrWidth'(videoPkg::regSolid):      rData <= 32'(cfg.solid);
                pAddrWidth'(videoPkg::regFrameCount): rData <= frameCount;
                default:                              rData <= '0;
            endcase
        end
    end

    // Host must see the response until it takes it.
    assert property (@(posedge iClk) disable iff (!rstN) bValid && !bReady |=> bValid)
        else $error("bValid dropped before bReady.");

endmodule

`default_nettype wire

//--- src/pixelPosGen.sv
// Active-area position counters with frame-start size latch, line-end and frame-done flags.
`timescale 1ns/1ps
`default_nettype none

module pixelPosGen
#(
    parameter int pCoordWidth = 12
)(
    input  wire logic               iClk,
    input  wire logic               rstN,
    input  wire videoPkg::videoCfgT cfg,
    input  wire logic               advance,   // Clock enable from the pattern stage.
    output videoPkg::pixelPosT      pos,
    output logic                    frameDone  // One cycle after the last pixel.
);

    logic [pCoordWidth-1:0] hCnt;
    logic [pCoordWidth-1:0] vCnt;
    logic [pCoordWidth-1:0] hLive;     // Register sizes with zero taken as one.
    logic [pCoordWidth-1:0] vLive;
    logic [pCoordWidth-1:0] hLatch;    // Sizes held for the current frame.
    logic [pCoordWidth-1:0] vLatch;
    logic [pCoordWidth-1:0] hSize;
    logic [pCoordWidth-1:0] vSize;
    logic                   atOrigin;
    logic                   lastCol;
    logic                   lastRow;

    assign hLive    = (pCoordWidth'(cfg.hActive) == '0) ? pCoordWidth'(1) : pCoordWidth'(cfg.hActive);
    assign vLive    = (pCoordWidth'(cfg.vActive) == '0) ? pCoordWidth'(1) : pCoordWidth'(cfg.vActive);
    assign atOrigin = (hCnt == '0) && (vCnt == '0);
    assign hSize    = atOrigin ? hLive : hLatch; // Live size until the first pixel leaves.
    assign vSize    = atOrigin ? vLive : vLatch;
    assign lastCol  = (hCnt == hSize - 1'b1);
    assign lastRow  = (vCnt == vSize - 1'b1);

    // Frame size follows the registers only while parked at the origin.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            hLatch <= pCoordWidth'(1);
            vLatch <= pCoordWidth'(1);
        end
        else if (atOrigin)
        begin
            hLatch <= hLive;
            vLatch <= vLive;
        end
    end

    // Raster counters.
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            hCnt <= '0;
            vCnt <= '0;
        end
        else if (advance)
        begin
            hCnt <= lastCol ? '0 : hCnt + 1'b1;
            if (lastCol)
                vCnt <= lastRow ? '0 : vCnt + 1'b1; // Next line or wrap.
        end
    end

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            frameDone <= 1'b0;
        else
            frameDone <= advance && lastCol && lastRow;
    end

    always_comb
    begin
        pos.hPos       = videoPkg::coordT'(hCnt);
        pos.vPos       = videoPkg::coordT'(vCnt);
        pos.frameStart = atOrigin;
        pos.lineEnd    = lastCol;
    end

    // Counters never leave the frame in use.
    assert property (@(posedge iClk) disable iff (!rstN) (hCnt < hSize) && (vCnt < vSize))
        else $error("Position outside latched frame size.");

endmodule

`default_nettype wire

//--- src/patternGen.sv
// Pattern stage with colour selection per position and the registered valid/ready pixel output.
`timescale 1ns/1ps
`default_nettype none

module patternGen
(
    input  wire logic               iClk,
    input  wire logic               rstN,
    input  wire videoPkg::videoCfgT cfg,
    input  wire videoPkg::pixelPosT pos,
    output logic                    advance,    // Take pos this cycle.
    output videoPkg::videoPixelT    pixel,
    output logic                    pixelValid,
    input  wire logic               pixelReady
);

    videoPkg::rgbT nextRgb;

    // Colour of one position for the selected pattern.
    function automatic videoPkg::rgbT patternColor(input videoPkg::patternT pattern,
                                                   input videoPkg::pixelPosT p,
                                                   input videoPkg::rgbT solid);
        logic [2:0]    barIdx;
        videoPkg::rgbT color;
        barIdx = p.hPos[6:4]; // 16-pixel bars.
        case (pattern)
            videoPkg::patGradient:
                color = {p.hPos[7:0], p.vPos[7:0], 8'h00};
            videoPkg::patChecker:
                color = (p.hPos[3] ^ p.vPos[3]) ? 24'hFF_FFFF : 24'h00_0000;
            videoPkg::patBars:
                color = {{8{barIdx[2]}}, {8{barIdx[1]}}, {8{barIdx[0]}}};
            default:
                color = solid;
        endcase
        return color;
    endfunction

    // Output slot free or draining this edge.
    assign advance = cfg.enable && (!pixelValid || pixelReady);
    assign nextRgb = patternColor(cfg.pattern, pos, cfg.solid);

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            pixelValid <= 1'b0;
        else if (advance)
            pixelValid <= 1'b1;
        else if (pixelReady)
            pixelValid <= 1'b0; // Last pixel taken and nothing new.
    end

    // Pixel payload held under stall.
    always_ff @(posedge iClk)
    begin
        if (advance)
        begin
            pixel.rgb <= nextRgb;
            pixel.sof <= pos.frameStart;
            pixel.eol <= pos.lineEnd;
        end
    end

    // Stream rule at the output.
    assert property (@(posedge iClk) disable iff (!rstN)
                     pixelValid && !pixelReady |=> pixelValid && $stable(pixel))
        else $error("Pixel changed while stalled.");

endmodule

`default_nettype wire

//--- src/videoTestSource.sv
// Top level: register block, position generator and pattern stage.
`timescale 1ns/1ps
`default_nettype none

module videoTestSource
#(
    parameter int pCoordWidth = 12,
    parameter int pAddrWidth  = 5
)(
    input  wire logic                  iClk,
    input  wire logic                  rstN,
    // AXI4-Lite slave.
    input  wire logic [pAddrWidth-1:0] awAddr,
    input  wire logic                  awValid,
    output logic                       awReady,
    input  wire logic [31:0]           wData,
    input  wire logic [3:0]            wStrb,
    input  wire logic                  wValid,
    output logic                       wReady,
    output videoPkg::axiRespT          bResp,
    output logic                       bValid,
    input  wire logic                  bReady,
    input  wire logic [pAddrWidth-1:0] arAddr,
    input  wire logic                  arValid,
    output logic                       arReady,
    output logic [31:0]                rData,
    output videoPkg::axiRespT          rResp,
    output logic                       rValid,
    input  wire logic                  rReady,
    // Pixel stream.
    output videoPkg::videoPixelT       pixel,
    output logic                       pixelValid,
    input  wire logic                  pixelReady
);

    videoPkg::videoCfgT cfg;       // Host configuration.
    videoPkg::pixelPosT pos;       // Next position.
    logic               advance;   // Stream-driven clock enable.
    logic               frameDone;

    axiLiteRegs #(.pAddrWidth(pAddrWidth)) uRegs
    (
        .iClk(iClk), .rstN(rstN),
        .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
        .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
        .bResp(bResp), .bValid(bValid), .bReady(bReady),
        .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
        .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
        .frameDone(frameDone), .cfg(cfg)
    );

    pixelPosGen #(.pCoordWidth(pCoordWidth)) uPosGen
    (
        .iClk(iClk), .rstN(rstN),
        .cfg(cfg), .advance(advance),
        .pos(pos), .frameDone(frameDone)
    );

    patternGen uPattern
    (
        .iClk(iClk), .rstN(rstN),
        .cfg(cfg), .pos(pos), .advance(advance),
        .pixel(pixel), .pixelValid(pixelValid), .pixelReady(pixelReady)
    );

endmodule

`default_nettype wire

//--- tb/tbAxiTasks.svh
// AXI4-Lite write and read tasks and the value check task.
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// Compare one value against its expected value and count a mismatch.
task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp)
    begin
        errorCount++;
        $display("CHECK FAILED at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
endtask

// One write with address and data offered together and each dropped once taken.
task automatic axiWrite(input videoPkg::regOffsetT offset, input logic [31:0] data,
                        input logic [3:0] strb);
    logic awFire;
    logic wFire;
    @(negedge iClk);
    awAddr  = pAddrWidth'(offset);
    wData   = data;
    wStrb   = strb;
    awValid = 1'b1;
    wValid  = 1'b1;
    while (awValid || wValid)
    begin
        awFire = awValid && awReady; // Ready settled at the last rising edge.
        wFire  = wValid && wReady;
        @(negedge iClk);
        if (awFire)
            awValid = 1'b0;
        if (wFire)
            wValid = 1'b0;
    end
    while (!bValid)
        @(negedge iClk);
    checkValue("bResp", 32'(bResp), 32'd0); // OKAY.
    @(negedge iClk);                 // bReady stays high, so the response is gone.
endtask

// One read with the data taken while rValid is high.
task automatic axiRead(input videoPkg::regOffsetT offset, output logic [31:0] data);
    logic arFire;
    @(negedge iClk);
    arAddr  = pAddrWidth'(offset);
    arValid = 1'b1;
    while (arValid)
    begin
        arFire = arReady;
        @(negedge iClk);
        if (arFire)
            arValid = 1'b0;
    end
    while (!rValid)
        @(negedge iClk);
    data = rData;
    checkValue("rResp", 32'(rResp), 32'd0); // OKAY.
    @(negedge iClk);
endtask

`endif

//--- tb/tbVideoTestSource.sv
// Testbench: clock, reset, LFSR back-pressure, reference pixel model, compare process, watchdog.
`timescale 1ns/1ps
`default_nettype none

module tbVideoTestSource;

    localparam int pCoordWidth   = 12;
    localparam int pAddrWidth    = 5;
    localparam int totalPixels   = 120 + 120 + 512 + 512 + 264 + 120; // All streamed tests.
    localparam int timeoutCycles = totalPixels * 4 + 2000;

    logic                  iClk;
    logic                  rstN;
    logic [pAddrWidth-1:0] awAddr;
    logic                  awValid;
    logic                  awReady;
    logic [31:0]           wData;
    logic [3:0]            wStrb;
    logic                  wValid;
    logic                  wReady;
    videoPkg::axiRespT     bResp;
    logic                  bValid;
    logic                  bReady;
    logic [pAddrWidth-1:0] arAddr;
    logic                  arValid;
    logic                  arReady;
    logic [31:0]           rData;
    videoPkg::axiRespT     rResp;
    logic                  rValid;
    logic                  rReady;
    videoPkg::videoPixelT  pixel;
    logic                  pixelValid;
    logic                  pixelReady   = 1'b0;

    int unsigned           errorCount   = 0;
    int unsigned           checkCount   = 0;
    int unsigned           accepted     = 0;    // Transfers seen on the stream.
    int unsigned           framesSeen   = 0;    // Frames whose last pixel was taken.
    int unsigned           readyLimit   = '1;   // Ready held low once this many are taken.
    int unsigned           streamTarget = 0;
    int unsigned           held;
    logic                  randomReady  = 1'b0;
    logic [31:0]           lfsrState    = 32'h266ced81;
    logic [31:0]           rd;
    videoPkg::patternT     curPattern   = videoPkg::patSolid;
    videoPkg::rgbT         shadowSolid  = '0;   // Host view of the registers.
    videoPkg::coordT       shadowW      = 12'd1;
    videoPkg::coordT       shadowH      = 12'd1;
    videoPkg::coordT       frameW       = 12'd1; // Size of the frame being checked.
    videoPkg::coordT       frameH       = 12'd1;
    videoPkg::coordT       expH         = '0;
    videoPkg::coordT       expV         = '0;

    `include "tbAxiTasks.svh"

    videoTestSource #(.pCoordWidth(pCoordWidth), .pAddrWidth(pAddrWidth)) DUT (.*);

    initial
    begin
        iClk = 1'b0;
        forever #20 iClk = ~iClk;
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Expected colour at a position.
    function automatic videoPkg::rgbT expectedRgb(input videoPkg::patternT pattern,
                                                  input videoPkg::coordT h,
                                                  input videoPkg::coordT v,
                                                  input videoPkg::rgbT solid);
        logic [2:0] bar;
        bar = h[6:4];
        if (pattern == videoPkg::patGradient)
            return {h[7:0], v[7:0], 8'h00};
        if (pattern == videoPkg::patChecker)
            return (h[3] != v[3]) ? 24'hFFFFFF : 24'h000000;
        if (pattern == videoPkg::patBars)
            return {bar[2] ? 8'hFF : 8'h00, bar[1] ? 8'hFF : 8'h00, bar[0] ? 8'hFF : 8'h00};
        return solid;
    endfunction

    // Back-pressure.
    always @(negedge iClk)
    begin
        if (randomReady)
            lfsrState = lfsrStep(lfsrState);
        pixelReady = (accepted < readyLimit) && (!randomReady || lfsrState[0]);
    end

    // Every transfer against the raster model.
    always @(posedge iClk)
    begin
        if (rstN && pixelValid && pixelReady)
        begin
            if (expH == '0 && expV == '0)
            begin
                frameW = (shadowW == '0) ? 12'd1 : shadowW; // Sizes fixed per frame.
                frameH = (shadowH == '0) ? 12'd1 : shadowH;
            end
            checkValue("pixel.rgb", 32'(pixel.rgb),
                       32'(expectedRgb(curPattern, expH, expV, shadowSolid)));
            checkValue("pixel.sof", 32'(pixel.sof), 32'(expH == '0 && expV == '0));
            checkValue("pixel.eol", 32'(pixel.eol), 32'(expH == frameW - 12'd1));
            accepted++;
            if (expH == frameW - 12'd1)
            begin
                expH = '0;
                if (expV == frameH - 12'd1)
                begin
                    expV = '0;
                    framesSeen++;
                end
                else
                    expV++;
            end
            else
                expH++;
        end
    end

    task automatic writeCtrl(input logic en, input videoPkg::patternT pattern);
        axiWrite(videoPkg::regCtrl, {29'd0, pattern, en}, 4'hF);
    endtask

    task automatic writeSize(input videoPkg::coordT w, input videoPkg::coordT h);
        axiWrite(videoPkg::regHActive, 32'(w), 4'hF);
        axiWrite(videoPkg::regVActive, 32'(h), 4'hF);
        shadowW = w;
        shadowH = h;
    endtask

    task automatic waitAccepted(input int unsigned n);
        while (accepted < n)
            @(negedge iClk);
    endtask

    // The last pixel is held back by ready so the stream can stop on a frame edge.
    task automatic startStream(input videoPkg::patternT pattern, input int unsigned count,
                               input logic useLfsr);
        streamTarget = accepted + count;
        readyLimit   = streamTarget - 1;
        randomReady  = useLfsr;
        curPattern   = pattern;
        writeCtrl(1'b1, pattern);
    endtask

    // Disable while stalled, drain the held pixel, then check count and frames.
    task automatic finishStream();
        logic [31:0] count;
        waitAccepted(streamTarget - 1);
        writeCtrl(1'b0, curPattern);
        readyLimit = streamTarget;
        waitAccepted(streamTarget);
        readyLimit = '1;
        repeat (10) @(negedge iClk);
        checkValue("pixel count", accepted, streamTarget);
        checkValue("pixelValid", 32'(pixelValid), 32'd0);
        axiRead(videoPkg::regFrameCount, count);
        checkValue("frameCount", count, framesSeen);
    endtask

    initial
    begin
        rstN    = 1'b0;
        awAddr  = '0;
        awValid = 1'b0;
        wData   = '0;
        wStrb   = '0;
        wValid  = 1'b0;
        bReady  = 1'b1;
        arAddr  = '0;
        arValid = 1'b0;
        rReady  = 1'b1;
        repeat (3) @(negedge iClk);
        rstN = 1'b1;

        // Register access.
        axiWrite(videoPkg::regCtrl, 32'h0000_0006, 4'hF);
        axiRead(videoPkg::regCtrl, rd);
        checkValue("ctrl", rd, 32'h0000_0006);
        axiWrite(videoPkg::regHActive, 32'h0000_0ABC, 4'hF);
        axiRead(videoPkg::regHActive, rd);
        checkValue("hActive", rd, 32'h0000_0ABC);
        axiWrite(videoPkg::regVActive, 32'h0000_0123, 4'hF);
        axiRead(videoPkg::regVActive, rd);
        checkValue("vActive", rd, 32'h0000_0123);
        axiWrite(videoPkg::regSolid, 32'h00A5_5A3C, 4'hF);
        axiWrite(videoPkg::regSolid, 32'h00FF_0000, 4'b0100); // Red lane only.
        axiRead(videoPkg::regSolid, rd);
        checkValue("solid", rd, 32'h00FF_5A3C);
        shadowSolid = 24'hFF_5A3C;
        axiWrite(videoPkg::regFrameCount, 32'h0000_FFFF, 4'hF);
        axiRead(videoPkg::regFrameCount, rd);
        checkValue("frameCount", rd, 32'd0);
        axiRead(8'h14, rd);
        checkValue("unmapped", rd, 32'd0);

        // Solid and gradient at full rate.
        writeSize(12'd20, 12'd6);
        startStream(videoPkg::patSolid, 120, 1'b0);
        finishStream();
        startStream(videoPkg::patGradient, 120, 1'b0);
        finishStream();

        // Checker and bars with random back-pressure.
        writeSize(12'd32, 12'd16);
        startStream(videoPkg::patChecker, 512, 1'b1);
        finishStream();
        writeSize(12'd128, 12'd4);
        startStream(videoPkg::patBars, 512, 1'b1);
        finishStream();

        // Width change 30 pixels into a 20x6 frame, next frame is 24x6.
        writeSize(12'd20, 12'd6);
        startStream(videoPkg::patGradient, 264, 1'b0);
        waitAccepted(streamTarget - 234);
        axiWrite(videoPkg::regHActive, 32'd24, 4'hF);
        shadowW = 12'd24;
        finishStream();

        // Disable mid-frame, then resume from the held position.
        writeSize(12'd20, 12'd6);
        startStream(videoPkg::patGradient, 120, 1'b0);
        waitAccepted(streamTarget - 70);
        writeCtrl(1'b0, videoPkg::patGradient);
        while (pixelValid)
            @(negedge iClk);
        held = accepted;
        repeat (20) @(negedge iClk);
        checkValue("transfers while disabled", accepted, held);
        writeCtrl(1'b1, videoPkg::patGradient);
        finishStream();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Watchdog.
    initial
    begin
        repeat (timeoutCycles) @(posedge iClk);
        $display("Timeout: the tests did not finish within %0d cycles.", timeoutCycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
src/videoPkg.sv
src/axiLiteRegs.sv
src/pixelPosGen.sv
src/patternGen.sv
src/videoTestSource.sv
tb/tbVideoTestSource.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tbVideoTestSource
FILELIST = sim.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
